/* ptp_phc_defs.svh */
// Field widths, APB register offsets, nominal clock period and PPS constants
`ifndef PTP_PHC_DEFS_SVH
`define PTP_PHC_DEFS_SVH

`define PTP_APB_ADDR_W 7
`define PTP_APB_DATA_W 32

`define PTP_NS_W 8
`define PTP_FNS_W 32
`define PTP_TOD_S_W 48
`define PTP_TOD_NS_W 30

`define PTP_NS_PER_S 1000000000
`define PTP_PPS_STR_NS 500000000

// Nominal period 512/165 ns
`define PTP_PER_NS_NUM 512
`define PTP_PER_NS_DENOM 165
`define PTP_NOM_PER_NS (`PTP_PER_NS_NUM / `PTP_PER_NS_DENOM)
`define PTP_NOM_PER_FNS \
    (((`PTP_PER_NS_NUM % `PTP_PER_NS_DENOM) * 64'h1_0000_0000) / `PTP_PER_NS_DENOM)

`define REG_STATUS 7'h0C
`define REG_CUR_FNS 7'h10
`define REG_CUR_NS 7'h14
`define REG_CUR_S_L 7'h18
`define REG_CUR_S_H 7'h1C
`define REG_SNAP_FNS 7'h30
`define REG_SNAP_NS 7'h34
`define REG_SNAP_S_L 7'h38
`define REG_SNAP_S_H 7'h3C
`define REG_OFS_TOD 7'h50
`define REG_SET_NS 7'h54
`define REG_SET_S_L 7'h58
`define REG_SET_S_H 7'h5C
`define REG_NOM_PER_FNS 7'h70
`define REG_NOM_PER_NS 7'h74
`define REG_PER_FNS 7'h78
`define REG_PER_NS 7'h7C

`endif

/* ptp_time_pkg.sv */
// Time-of-day, command payload and period types of the clock core
`include "ptp_phc_defs.svh"

package ptp_time_pkg;

// Full time of day, 110 bits
typedef struct packed {
    logic [`PTP_TOD_S_W-1:0]  s;
    logic [`PTP_TOD_NS_W-1:0] ns;
    logic [`PTP_FNS_W-1:0]    fns;  // Fractional ns
} tod_t;

// Set command, fns is cleared by the core
typedef struct packed {
    logic [`PTP_TOD_S_W-1:0]  s;
    logic [`PTP_TOD_NS_W-1:0] ns;
} tod_set_t;

// Unsigned ns offset
typedef logic [`PTP_TOD_NS_W-1:0] tod_offset_t;

// Increment added every cycle
typedef struct packed {
    logic [`PTP_NS_W-1:0]  ns;
    logic [`PTP_FNS_W-1:0] fns;
} period_t;

endpackage

/* ptp_reg_pkg.sv */
// Register address type, word alignment and status bit positions of the APB block
`include "ptp_phc_defs.svh"

package ptp_reg_pkg;

typedef logic [`PTP_APB_ADDR_W-1:0] reg_addr_t;

// Bit positions in the status register
typedef enum logic [4:0] {
    PPS_STR  = 5'd8,
    SET_PEND = 5'd24,
    OFS_PEND = 5'd25,
    PER_PEND = 5'd28
} status_bit_e;

// Drop the byte lanes, registers are whole words
function automatic reg_addr_t word_addr(input reg_addr_t addr);
    reg_addr_t aligned;
    aligned = addr;
    aligned[1:0] = 2'b00;
    return aligned;
endfunction

endpackage

/* ptp_cmd_slot.sv */
// One-deep pending command holder with valid/ready output, any payload type
`timescale 1ns/1ns

module ptp_cmd_slot
    import ptp_time_pkg::*;
#(
    parameter type payload_t = tod_set_t
) (
    input  logic     clk,
    input  logic     ptp_rst,
    input  logic     load,
    input  payload_t load_data,
    output logic     valid,
    output payload_t data,
    input  logic     ready,
    output logic     pending
);

logic     valid_reg;
payload_t data_reg;

always_ff @(posedge clk) begin
    if (ptp_rst) begin
        valid_reg <= 1'b0;
    end else if (valid_reg) begin
        if (ready) begin
            valid_reg <= 1'b0;  // Taken by the core
        end
    end else if (load) begin
        valid_reg <= 1'b1;
    end
end

// A load while busy is dropped
always_ff @(posedge clk) begin
    if (load && !valid_reg) begin
        data_reg <= load_data;
    end
end

assign valid   = valid_reg;
assign data    = data_reg;
assign pending = valid_reg;

endmodule

/* ptp_phc_apb_regs.sv */
// APB slave with command staging registers, read mux and time snapshot
`timescale 1ns/1ns
`include "ptp_phc_defs.svh"

module ptp_phc_apb_regs
    import ptp_time_pkg::*;
    import ptp_reg_pkg::*;
(
    input  logic                       clk,
    input  logic                       ptp_rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  reg_addr_t                  paddr,
    input  logic [`PTP_APB_DATA_W-1:0] pwdata,
    output logic                       pready,
    output logic [`PTP_APB_DATA_W-1:0] prdata,
    output logic                       set_load,
    output tod_set_t                   set_data,
    input  logic                       set_pending,
    output logic                       ofs_load,
    output tod_offset_t                ofs_data,
    input  logic                       ofs_pending,
    output logic                       per_load,
    output period_t                    per_data,
    input  logic                       per_pending,
    input  tod_t                       cur_tod,
    input  logic                       pps_str
);

logic                       pready_reg;
logic [`PTP_APB_DATA_W-1:0] prdata_reg;
logic                       set_load_reg;
logic                       ofs_load_reg;
logic                       per_load_reg;
logic [`PTP_TOD_S_W-1:0]    set_s_reg;
logic [`PTP_TOD_NS_W-1:0]   set_ns_reg;
tod_offset_t                ofs_reg;
logic [`PTP_NS_W-1:0]       per_ns_reg;
logic [`PTP_FNS_W-1:0]      per_fns_reg;
tod_set_t                   snap_reg;
logic                       access;
reg_addr_t                  addr;
logic [`PTP_APB_DATA_W-1:0] status_word;
logic [`PTP_APB_DATA_W-1:0] rdata;

assign access = psel && penable && !pready_reg;  // First access cycle only
assign addr   = word_addr(paddr);

always_comb begin
    status_word = '0;
    status_word[PPS_STR]  = pps_str;
    status_word[SET_PEND] = set_pending;
    status_word[OFS_PEND] = ofs_pending;
    status_word[PER_PEND] = per_pending;
end

always_comb begin
    case (addr)
        `REG_STATUS:      rdata = status_word;
        `REG_CUR_FNS,
        `REG_SNAP_FNS:    rdata = {cur_tod.fns[`PTP_FNS_W-1:16], 16'd0};
        `REG_CUR_NS:      rdata = 32'(cur_tod.ns);
        `REG_CUR_S_L:     rdata = cur_tod.s[31:0];
        `REG_CUR_S_H:     rdata = 32'(cur_tod.s[`PTP_TOD_S_W-1:32]);
        `REG_SNAP_NS:     rdata = 32'(snap_reg.ns);
        `REG_SNAP_S_L:    rdata = snap_reg.s[31:0];
        `REG_SNAP_S_H:    rdata = 32'(snap_reg.s[`PTP_TOD_S_W-1:32]);
        `REG_OFS_TOD:     rdata = 32'(ofs_reg);
        `REG_SET_NS:      rdata = 32'(set_ns_reg);
        `REG_SET_S_L:     rdata = set_s_reg[31:0];
        `REG_SET_S_H:     rdata = 32'(set_s_reg[`PTP_TOD_S_W-1:32]);
        `REG_NOM_PER_FNS: rdata = 32'(`PTP_NOM_PER_FNS);
        `REG_NOM_PER_NS:  rdata = 32'(`PTP_NOM_PER_NS);
        `REG_PER_FNS:     rdata = 32'(per_fns_reg);
        `REG_PER_NS:      rdata = 32'(per_ns_reg);
        default:          rdata = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (ptp_rst) begin
        pready_reg   <= 1'b0;
        set_load_reg <= 1'b0;
        ofs_load_reg <= 1'b0;
        per_load_reg <= 1'b0;
        set_s_reg    <= '0;
        set_ns_reg   <= '0;
        ofs_reg      <= '0;
        per_ns_reg   <= `PTP_NS_W'(`PTP_NOM_PER_NS);
        per_fns_reg  <= `PTP_FNS_W'(`PTP_NOM_PER_FNS);
    end else begin
        pready_reg   <= access;
        set_load_reg <= 1'b0;
        ofs_load_reg <= 1'b0;
        per_load_reg <= 1'b0;
        if (access && pwrite) begin
            case (addr)
                `REG_OFS_TOD: begin
                    ofs_reg      <= tod_offset_t'(pwdata);
                    ofs_load_reg <= tod_offset_t'(pwdata) != '0;  // Zero is a no-op
                end
                `REG_SET_NS:  set_ns_reg <= `PTP_TOD_NS_W'(pwdata);
                `REG_SET_S_L: set_s_reg[31:0] <= pwdata;
                `REG_SET_S_H: begin
                    set_s_reg[`PTP_TOD_S_W-1:32] <= (`PTP_TOD_S_W-32)'(pwdata);
                    set_load_reg <= 1'b1;
                end
                `REG_PER_FNS: per_fns_reg <= `PTP_FNS_W'(pwdata);
                `REG_PER_NS: begin
                    per_ns_reg   <= `PTP_NS_W'(pwdata);
                    per_load_reg <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    if (access) begin
        prdata_reg <= rdata;
    end
    if (access && !pwrite && addr == `REG_SNAP_FNS) begin
        snap_reg <= '{s: cur_tod.s, ns: cur_tod.ns};  // Whole time in one cycle
    end
end

assign pready   = pready_reg;
assign prdata   = prdata_reg;
assign set_load = set_load_reg;
assign set_data = '{s: set_s_reg, ns: set_ns_reg};
assign ofs_load = ofs_load_reg;
assign ofs_data = ofs_reg;
assign per_load = per_load_reg;
assign per_data = '{ns: per_ns_reg, fns: per_fns_reg};

endmodule

/* ptp_phc_core.sv */
// Clock core with command arbitration, time-of-day accumulator and PPS outputs
`timescale 1ns/1ns
`include "ptp_phc_defs.svh"

module ptp_phc_core
    import ptp_time_pkg::*;
(
    input  logic        clk,
    input  logic        ptp_rst,
    input  logic        set_valid,
    input  tod_set_t    set_data,
    output logic        set_ready,
    input  logic        ofs_valid,
    input  tod_offset_t ofs_data,
    output logic        ofs_ready,
    input  logic        per_valid,
    input  period_t     per_data,
    output logic        per_ready,
    output tod_t        cur_tod,
    output logic        pps,
    output logic        pps_str
);

localparam logic [31:0] NS_PER_S  = 32'(`PTP_NS_PER_S);
localparam logic [31:0] NS_PER_2S = 2 * NS_PER_S;

logic [`PTP_TOD_S_W-1:0]  s_reg;
logic [`PTP_TOD_NS_W-1:0] ns_reg;
logic [`PTP_FNS_W-1:0]    fns_reg;
period_t                  period_reg;
logic                     pps_reg;
logic                     pps_str_reg;
logic [`PTP_FNS_W:0]      fns_sum;
logic [31:0]              ns_sum;
logic [31:0]              ns_norm;
logic [1:0]               s_carry;
logic                     tick_wrap;

// Fixed priority, one grant per cycle
assign set_ready = set_valid;
assign ofs_ready = ofs_valid && !set_valid;
assign per_ready = per_valid && !set_valid && !ofs_valid;

always_comb begin
    fns_sum = {1'b0, fns_reg} + {1'b0, period_reg.fns};
    ns_sum  = 32'(ns_reg) + 32'(period_reg.ns) + 32'(fns_sum[`PTP_FNS_W]);
    if (ofs_ready) begin
        ns_sum = ns_sum + 32'(ofs_data);
    end
    // An offset can push ns past two seconds' worth
    if (ns_sum >= NS_PER_2S) begin
        ns_norm = ns_sum - NS_PER_2S;
        s_carry = 2'd2;
    end else if (ns_sum >= NS_PER_S) begin
        ns_norm = ns_sum - NS_PER_S;
        s_carry = 2'd1;
    end else begin
        ns_norm = ns_sum;
        s_carry = 2'd0;
    end
end

// PPS only marks a plain advance across the second
assign tick_wrap = (s_carry != 2'd0) && !set_ready && !ofs_ready;

always_ff @(posedge clk) begin
    if (ptp_rst) begin
        s_reg       <= '0;
        ns_reg      <= '0;
        fns_reg     <= '0;
        period_reg  <= '{ns: `PTP_NS_W'(`PTP_NOM_PER_NS), fns: `PTP_FNS_W'(`PTP_NOM_PER_FNS)};
        pps_reg     <= 1'b0;
        pps_str_reg <= 1'b0;
    end else begin
        if (set_ready) begin
            s_reg   <= set_data.s;
            ns_reg  <= set_data.ns;
            fns_reg <= '0;
        end else begin
            s_reg   <= s_reg + `PTP_TOD_S_W'(s_carry);
            ns_reg  <= `PTP_TOD_NS_W'(ns_norm);
            fns_reg <= fns_sum[`PTP_FNS_W-1:0];
        end

        if (per_ready) begin
            period_reg <= per_data;  // Used from the next cycle
        end

        pps_reg <= tick_wrap;
        if (tick_wrap) begin
            pps_str_reg <= 1'b1;
        end else if (ns_reg >= `PTP_TOD_NS_W'(`PTP_PPS_STR_NS)) begin
            pps_str_reg <= 1'b0;  // Half second reached
        end
    end
end

assign cur_tod = '{s: s_reg, ns: ns_reg, fns: fns_reg};
assign pps     = pps_reg;
assign pps_str = pps_str_reg;

endmodule

/* ptp_phc_apb.sv */
// PTP hardware clock top level with register block, command slots and core
`timescale 1ns/1ns
`include "ptp_phc_defs.svh"

module ptp_phc_apb
    import ptp_time_pkg::*;
(
    input  logic                       clk,
    input  logic                       ptp_rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`PTP_APB_ADDR_W-1:0] paddr,
    input  logic [`PTP_APB_DATA_W-1:0] pwdata,
    output logic                       pready,
    output logic [`PTP_APB_DATA_W-1:0] prdata,
    output logic                       ptp_pps,
    output logic                       ptp_pps_str
);

logic        set_load;
tod_set_t    set_load_data;
logic        set_pending;
logic        set_valid;
tod_set_t    set_data;
logic        set_ready;
logic        ofs_load;
tod_offset_t ofs_load_data;
logic        ofs_pending;
logic        ofs_valid;
tod_offset_t ofs_data;
logic        ofs_ready;
logic        per_load;
period_t     per_load_data;
logic        per_pending;
logic        per_valid;
period_t     per_data;
logic        per_ready;
tod_t        cur_tod;

ptp_phc_apb_regs regs_i (
    .clk         (clk),
    .ptp_rst     (ptp_rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .prdata      (prdata),
    .set_load    (set_load),
    .set_data    (set_load_data),
    .set_pending (set_pending),
    .ofs_load    (ofs_load),
    .ofs_data    (ofs_load_data),
    .ofs_pending (ofs_pending),
    .per_load    (per_load),
    .per_data    (per_load_data),
    .per_pending (per_pending),
    .cur_tod     (cur_tod),
    .pps_str     (ptp_pps_str)
);

ptp_cmd_slot #(.payload_t(tod_set_t)) set_slot_i (
    .clk       (clk),
    .ptp_rst   (ptp_rst),
    .load      (set_load),
    .load_data (set_load_data),
    .valid     (set_valid),
    .data      (set_data),
    .ready     (set_ready),
    .pending   (set_pending)
);

ptp_cmd_slot #(.payload_t(tod_offset_t)) ofs_slot_i (
    .clk       (clk),
    .ptp_rst   (ptp_rst),
    .load      (ofs_load),
    .load_data (ofs_load_data),
    .valid     (ofs_valid),
    .data      (ofs_data),
    .ready     (ofs_ready),
    .pending   (ofs_pending)
);

ptp_cmd_slot #(.payload_t(period_t)) per_slot_i (
    .clk       (clk),
    .ptp_rst   (ptp_rst),
    .load      (per_load),
    .load_data (per_load_data),
    .valid     (per_valid),
    .data      (per_data),
    .ready     (per_ready),
    .pending   (per_pending)
);

ptp_phc_core core_i (
    .clk       (clk),
    .ptp_rst   (ptp_rst),
    .set_valid (set_valid),
    .set_data  (set_data),
    .set_ready (set_ready),
    .ofs_valid (ofs_valid),
    .ofs_data  (ofs_data),
    .ofs_ready (ofs_ready),
    .per_valid (per_valid),
    .per_data  (per_data),
    .per_ready (per_ready),
    .cur_tod   (cur_tod),
    .pps       (ptp_pps),
    .pps_str   (ptp_pps_str)
);

endmodule

/* ptp_phc_apb_sva.sv */
// Bound assertions on APB pready, PPS pulse width and command slot handshakes
`timescale 1ns/1ns

module ptp_phc_apb_sva (
    input logic clk,
    input logic ptp_rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic ptp_pps,
    input logic set_valid,
    input logic set_ready,
    input logic ofs_valid,
    input logic ofs_ready,
    input logic per_valid,
    input logic per_ready
);

pready_pulse: assert property (@(posedge clk) disable iff (ptp_rst) pready |=> !pready)
    else $error("pready stayed high for a second cycle");

pready_in_access: assert property (@(posedge clk) disable iff (ptp_rst)
    pready |-> psel && penable)
    else $error("pready high outside an APB access phase");

pps_pulse: assert property (@(posedge clk) disable iff (ptp_rst) ptp_pps |=> !ptp_pps)
    else $error("ptp_pps lasted two cycles");

set_handshake: assert property (@(posedge clk) disable iff (ptp_rst)
    set_valid && set_ready |=> !set_valid)
    else $error("set slot valid did not fall after ready");

ofs_handshake: assert property (@(posedge clk) disable iff (ptp_rst)
    ofs_valid && ofs_ready |=> !ofs_valid)
    else $error("offset slot valid did not fall after ready");

per_handshake: assert property (@(posedge clk) disable iff (ptp_rst)
    per_valid && per_ready |=> !per_valid)
    else $error("period slot valid did not fall after ready");

endmodule

bind ptp_phc_apb ptp_phc_apb_sva sva_i (
    .clk       (clk),
    .ptp_rst   (ptp_rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .ptp_pps   (ptp_pps),
    .set_valid (set_valid),
    .set_ready (set_ready),
    .ofs_valid (ofs_valid),
    .ofs_ready (ofs_ready),
    .per_valid (per_valid),
    .per_ready (per_ready)
);

/* tb_clk_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic ptp_rst
);

localparam int HALF_PERIOD = 5;  // 10 ns clock

initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
end

initial begin
    ptp_rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 ptp_rst = 1'b0;  // Two cycles of reset
end

endmodule

/* tb_ptp_phc_apb.sv */
// Testbench with APB tasks, time-of-day reference function and read checker
`timescale 1ns/1ns
`include "ptp_phc_defs.svh"

module tb_ptp_phc_apb
    import ptp_time_pkg::*;
    import ptp_reg_pkg::*;
();

localparam int APB_TIMEOUT = 20;
localparam int POLL_LIMIT = 50;
localparam int PPS_TIMEOUT = 2000;
localparam longint NS_PER_S = 1000000000;
localparam int PER_NUM = 512;
localparam int PER_DEN = 165;
localparam logic [31:0] NOM_NS = 32'(PER_NUM / PER_DEN);
localparam logic [31:0] NOM_FNS = 32'((longint'(PER_NUM % PER_DEN) << 32) / PER_DEN);

logic        clk;
logic        ptp_rst;
logic        psel;
logic        penable;
logic        pwrite;
logic [6:0]  paddr;
logic [31:0] pwdata;
logic        pready;
logic [31:0] prdata;
logic        ptp_pps;
logic        ptp_pps_str;
int          errors;
int          checks;
logic [31:0] got_q[$];
logic [31:0] exp_q[$];
string       name_q[$];

tb_clk_gen clk_gen_i (
    .clk     (clk),
    .ptp_rst (ptp_rst)
);

ptp_phc_apb dut_i (
    .clk         (clk),
    .ptp_rst     (ptp_rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .prdata      (prdata),
    .ptp_pps     (ptp_pps),
    .ptp_pps_str (ptp_pps_str)
);

// Expected time after an offset with ns kept below one second
function automatic tod_set_t tod_add(input tod_set_t t, input tod_offset_t ofs);
    tod_set_t r;
    longint   ns_sum;
    ns_sum = longint'(t.ns) + longint'(ofs);
    r.s = t.s;
    while (ns_sum >= NS_PER_S) begin
        ns_sum = ns_sum - NS_PER_S;
        r.s = r.s + 48'd1;
    end
    r.ns = 30'(ns_sum);
    return r;
endfunction

function automatic tod_set_t random_tod();
    tod_set_t t;
    t.s = {16'($urandom), $urandom};
    t.ns = 30'($urandom % 32'd1000000000);
    return t;
endfunction

function automatic void push_check(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
endfunction

task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
endtask

task automatic timeout_abort(input string what);
    errors++;
    $display("Timeout at %0t ns: no %s within the wait limit", $time, what);
    finish_run();
endtask

// Starts and returns 1 ns after a rising edge
task automatic apb_access(input logic write, input logic [6:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited = 0;
    do begin
        @(posedge clk);
        #1;
        waited++;
    end while (!pready && waited < APB_TIMEOUT);
    if (!pready) begin
        timeout_abort("pready");
    end
    rdata = prdata;
    @(posedge clk);  // Transfer completes on this edge
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic expect_reg(input logic [6:0] addr, input logic [31:0] exp,
                          input string name);
    logic [31:0] got;
    apb_access(1'b0, addr, '0, got);
    push_check({"prdata (", name, ")"}, got, exp);
endtask

task automatic expect_status_bit(input status_bit_e pos, input logic val,
                                 input string name);
    logic [31:0] status;
    apb_access(1'b0, `REG_STATUS, '0, status);
    push_check({"prdata (status.", name, ")"}, 32'(status[pos]), 32'(val));
endtask

// Offset slot stays idle for a few cycles
task automatic expect_ofs_idle(input int cycles);
    repeat (cycles) begin
        push_check("ofs_pending", 32'(dut_i.ofs_pending), 32'd0);
        @(posedge clk);
        #1;
    end
endtask

task automatic wait_pending_clear(input status_bit_e pos, input string what);
    logic [31:0] status;
    int          polls;
    polls = 0;
    do begin
        apb_access(1'b0, `REG_STATUS, '0, status);
        polls++;
    end while (status[pos] && polls < POLL_LIMIT);
    if (status[pos]) begin
        timeout_abort(what);
    end
endtask

task automatic wait_for_pps();
    int waited;
    waited = 0;
    do begin
        @(posedge clk);
        #1;
        waited++;
    end while (!ptp_pps && waited < PPS_TIMEOUT);
    if (!ptp_pps) begin
        timeout_abort("ptp_pps pulse");
    end
endtask

task automatic set_time(input tod_set_t t);
    write_reg(`REG_SET_NS, 32'(t.ns));
    write_reg(`REG_SET_S_L, t.s[31:0]);
    write_reg(`REG_SET_S_H, 32'(t.s[47:32]));  // Issues the set
    wait_pending_clear(SET_PEND, "set pending clear");
endtask

task automatic set_period(input logic [7:0] ns, input logic [31:0] fns);
    write_reg(`REG_PER_FNS, fns);
    write_reg(`REG_PER_NS, 32'(ns));
    wait_pending_clear(PER_PEND, "period pending clear");
endtask

task automatic apply_offset(input tod_offset_t ofs);
    write_reg(`REG_OFS_TOD, 32'(ofs));
    wait_pending_clear(OFS_PEND, "offset pending clear");
endtask

// Reads ns, seconds low and seconds high from consecutive words
task automatic check_time(input logic [6:0] ns_addr, input tod_set_t t,
                          input string prefix);
    expect_reg(ns_addr, 32'(t.ns), {prefix, "_ns"});
    expect_reg(ns_addr + 7'h4, t.s[31:0], {prefix, "_s_l"});
    expect_reg(ns_addr + 7'h8, 32'(t.s[47:32]), {prefix, "_s_h"});
endtask

always @(posedge clk) begin : compare_reads
    logic [31:0] got;
    logic [31:0] exp;
    string       name;
    while (got_q.size() != 0) begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        name = name_q.pop_front();
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
        end
    end
end

initial begin : stimulus
    tod_set_t    exp_tod;
    tod_set_t    snap_tod;
    tod_offset_t ofs;
    int          waited;
    void'($urandom(52741));
    errors = 0;
    checks = 0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
    end while (ptp_rst && waited < 10);
    if (ptp_rst) begin
        timeout_abort("reset release");
    end
    #1;

    expect_reg(`REG_NOM_PER_FNS, NOM_FNS, "nom_per_fns");
    expect_reg(`REG_NOM_PER_NS, NOM_NS, "nom_per_ns");
    expect_reg(`REG_PER_FNS, NOM_FNS, "per_fns");
    expect_reg(`REG_PER_NS, NOM_NS, "per_ns");
    expect_status_bit(SET_PEND, 1'b0, "set_pend");
    expect_status_bit(OFS_PEND, 1'b0, "ofs_pend");
    expect_status_bit(PER_PEND, 1'b0, "per_pend");

    set_period(8'd0, 32'd0);  // Time stands still
    exp_tod = random_tod();
    set_time(exp_tod);
    check_time(`REG_CUR_NS, exp_tod, "cur");

    repeat (4) begin
        ofs = tod_offset_t'($urandom);
        if (ofs == '0) begin
            ofs = 30'd1;
        end
        apply_offset(ofs);
        exp_tod = tod_add(exp_tod, ofs);
        check_time(`REG_CUR_NS, exp_tod, "cur");
    end
    ofs = tod_offset_t'(NS_PER_S - longint'(exp_tod.ns) + 5);  // Forces a carry
    apply_offset(ofs);
    exp_tod = tod_add(exp_tod, ofs);
    check_time(`REG_CUR_NS, exp_tod, "cur");
    write_reg(`REG_OFS_TOD, 32'd0);
    expect_ofs_idle(3);
    check_time(`REG_CUR_NS, exp_tod, "cur");

    expect_reg(`REG_SNAP_FNS, 32'd0, "snap_fns");
    snap_tod = exp_tod;
    exp_tod = random_tod();
    set_time(exp_tod);
    check_time(`REG_SNAP_NS, snap_tod, "snap");
    check_time(`REG_CUR_NS, exp_tod, "cur");

    exp_tod.ns = 30'd999999000;
    set_time(exp_tod);
    set_period(8'd8, 32'd0);
    wait_for_pps();
    push_check("ptp_pps_str", 32'(ptp_pps_str), 32'd1);  // Rises with ptp_pps
    exp_tod.s = exp_tod.s + 48'd1;
    expect_reg(`REG_CUR_S_L, exp_tod.s[31:0], "cur_s_l");
    expect_reg(`REG_CUR_S_H, 32'(exp_tod.s[47:32]), "cur_s_h");
    expect_status_bit(PPS_STR, 1'b1, "pps_str");
    set_period(8'd0, 32'd0);
    exp_tod.ns = 30'd600000000;  // Past the half second
    set_time(exp_tod);
    expect_status_bit(PPS_STR, 1'b0, "pps_str");
    push_check("ptp_pps_str", 32'(ptp_pps_str), 32'd0);

    @(posedge clk);
    #1;
    finish_run();
end

endmodule

/* ptp_phc_apb.f */
+incdir+.
ptp_time_pkg.sv
ptp_reg_pkg.sv
ptp_cmd_slot.sv
ptp_phc_apb_regs.sv
ptp_phc_core.sv
ptp_phc_apb.sv
ptp_phc_apb_sva.sv
tb_clk_gen.sv
tb_ptp_phc_apb.sv

/* Makefile */
TOP = tb_ptp_phc_apb

sim:
	verilator --binary --timing --assert -f ptp_phc_apb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "** FAIL **" >> sim.log
	cat sim.log
	! grep -q "\*\* FAIL \*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
